/* Bender.yml */
package:
  name: c64_loader

sources:
  - files:
      - hdl/loader_pkg.sv
      - hdl/mem_slot_writer.sv
      - hdl/crt_header_parser.sv
      - hdl/basic_ptr_patch.sv
      - hdl/load_control.sv
      - hdl/c64_loader_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_c64_loader.sv

/* hdl/basic_ptr_patch.sv */
/*
 * Tracks the PRG start and end address and returns the BASIC pointer bytes.
 * The control block walks zero page and asks for each address in turn.
 */
`timescale 1ns/1ns
`default_nettype none

module basic_ptr_patch (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	input  wire                        prg_addr_lo_i,
	input  wire                        prg_addr_hi_i,
	input  wire                        prg_payload_i,
	input  wire loader_pkg::byte_t     dl_data_i,
	input  wire loader_pkg::mem_addr_t sweep_addr_i,
	output logic                       ptr_hit_o,
	output loader_pkg::byte_t          ptr_data_o
);
	import loader_pkg::*;

	word_t start_addr;
	word_t end_addr;

	// End address starts at the load address and grows per payload byte
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			start_addr <= '0;
			end_addr   <= '0;
		end else if (prg_addr_lo_i) begin
			start_addr[7:0] <= dl_data_i;
			end_addr[7:0]   <= dl_data_i;
		end else if (prg_addr_hi_i) begin
			start_addr[15:8] <= dl_data_i;
			end_addr[15:8]   <= dl_data_i;
		end else if (prg_payload_i) begin
			end_addr <= end_addr + 16'd1;
		end
	end

	always_comb begin
		ptr_hit_o  = 1'b1;
		ptr_data_o = '0;
		case (sweep_addr_i)
			PTR_TXT_LO, PTR_SAVE_START:         ptr_data_o = start_addr[7:0];
			PTR_TXT_HI, PTR_SAVE_START + 25'd1: ptr_data_o = start_addr[15:8];
			PTR_VAR, PTR_ARY, PTR_STR, PTR_LOAD_END: begin
				ptr_data_o = end_addr[7:0];
			end
			PTR_VAR + 25'd1, PTR_ARY + 25'd1, PTR_STR + 25'd1, PTR_LOAD_END + 25'd1: begin
				ptr_data_o = end_addr[15:8];
			end
			default: ptr_hit_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/c64_loader_top.sv */
/*
 * Media loader top level: downloader stream in, slot-timed memory writes out.
 * Connects control, CRT parser, pointer patch and slot writer.
 */
`timescale 1ns/1ns
`default_nettype none

module c64_loader_top #(
	parameter loader_pkg::mem_addr_t CRT_BASE = 25'h100000
) (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	input  wire                        dl_active_i,
	input  wire loader_pkg::dl_index_t dl_index_i,
	input  wire                        dl_wr_i,
	input  wire loader_pkg::mem_addr_t dl_addr_i,
	input  wire loader_pkg::byte_t     dl_data_i,
	input  wire                        slot_i,
	output wire                        dl_wait_o,
	output wire                        mem_we_o,
	output wire loader_pkg::mem_addr_t mem_addr_o,
	output wire loader_pkg::byte_t     mem_data_o,
	output wire                        inj_done_o,
	output wire                        cart_attached_o,
	output wire loader_pkg::word_t     cart_id_o,
	output wire loader_pkg::byte_t     cart_exrom_o,
	output wire loader_pkg::byte_t     cart_game_o,
	output wire                        bank_valid_o,
	output wire loader_pkg::byte_t     bank_type_o,
	output wire loader_pkg::word_t     bank_num_o,
	output wire loader_pkg::word_t     bank_laddr_o,
	output wire loader_pkg::word_t     bank_size_o
);
	import loader_pkg::*;

	wire            crt_byte;
	wire            crt_payload;
	wire            crt_align;
	wire            prg_payload;
	wire            prg_addr_lo;
	wire            prg_addr_hi;
	wire mem_addr_t sweep_addr;
	wire            ptr_hit;
	wire byte_t     ptr_data;
	wire            req_valid;
	wire mem_addr_t req_addr;
	wire byte_t     req_data;

	load_control #(
		.CRT_BASE(CRT_BASE)
	) u_control (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_wr_i        (dl_wr_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.crt_payload_i  (crt_payload),
		.crt_align_i    (crt_align),
		.ptr_hit_i      (ptr_hit),
		.ptr_data_i     (ptr_data),
		.writer_busy_i  (dl_wait_o),
		.crt_byte_o     (crt_byte),
		.prg_payload_o  (prg_payload),
		.prg_addr_lo_o  (prg_addr_lo),
		.prg_addr_hi_o  (prg_addr_hi),
		.sweep_addr_o   (sweep_addr),
		.req_valid_o    (req_valid),
		.req_addr_o     (req_addr),
		.req_data_o     (req_data),
		.inj_done_o     (inj_done_o),
		.cart_attached_o(cart_attached_o)
	);

	crt_header_parser u_crt (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.crt_byte_i  (crt_byte),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.payload_o   (crt_payload),
		.align_o     (crt_align),
		.cart_id_o   (cart_id_o),
		.cart_exrom_o(cart_exrom_o),
		.cart_game_o (cart_game_o),
		.bank_valid_o(bank_valid_o),
		.bank_type_o (bank_type_o),
		.bank_num_o  (bank_num_o),
		.bank_laddr_o(bank_laddr_o),
		.bank_size_o (bank_size_o)
	);

	basic_ptr_patch u_patch (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.prg_addr_lo_i(prg_addr_lo),
		.prg_addr_hi_i(prg_addr_hi),
		.prg_payload_i(prg_payload),
		.dl_data_i    (dl_data_i),
		.sweep_addr_i (sweep_addr),
		.ptr_hit_o    (ptr_hit),
		.ptr_data_o   (ptr_data)
	);

	// Busy writer doubles as the downloader wait
	mem_slot_writer u_writer (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.req_valid_i(req_valid),
		.req_addr_i (req_addr),
		.req_data_i (req_data),
		.slot_i     (slot_i),
		.busy_o     (dl_wait_o),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

endmodule

`default_nettype wire

/* hdl/crt_header_parser.sv */
/*
 * CRT stream parser: captures the file header and every CHIP chunk header.
 * Flags each byte as chunk start or payload in the cycle it arrives.
 */
`timescale 1ns/1ns
`default_nettype none

module crt_header_parser (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	input  wire                        crt_byte_i,
	input  wire loader_pkg::mem_addr_t dl_addr_i,
	input  wire loader_pkg::byte_t     dl_data_i,
	output logic                       payload_o,
	output logic                       align_o,
	output loader_pkg::word_t          cart_id_o,
	output loader_pkg::byte_t          cart_exrom_o,
	output loader_pkg::byte_t          cart_game_o,
	output logic                       bank_valid_o,
	output loader_pkg::byte_t          bank_type_o,
	output loader_pkg::word_t          bank_num_o,
	output loader_pkg::word_t          bank_laddr_o,
	output loader_pkg::word_t          bank_size_o
);
	import loader_pkg::*;

	logic        in_chunks;
	logic [3:0]  hdr_cnt;
	logic [31:0] blk_len;

	assign in_chunks = crt_byte_i && (dl_addr_i >= CRT_CHIP_OFFSET);
	// Nothing left of the previous chunk, so this byte opens a new one
	assign align_o   = in_chunks && (hdr_cnt == 4'd0) && (blk_len == 32'd0);
	assign payload_o = in_chunks && (hdr_cnt == 4'd0) && (blk_len != 32'd0);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_cnt      <= '0;
			blk_len      <= '0;
			cart_id_o    <= '0;
			cart_exrom_o <= '0;
			cart_game_o  <= '0;
			bank_valid_o <= 1'b0;
			bank_type_o  <= '0;
			bank_num_o   <= '0;
			bank_laddr_o <= '0;
			bank_size_o  <= '0;
		end else begin
			bank_valid_o <= 1'b0;
			if (crt_byte_i) begin
				// ========================================
				// File header
				// ========================================
				case (dl_addr_i)
					25'h00: begin
						hdr_cnt <= '0;
						blk_len <= '0;
					end
					25'h16: cart_id_o[15:8] <= dl_data_i;
					25'h17: cart_id_o[7:0]  <= dl_data_i;
					25'h18: cart_exrom_o    <= dl_data_i;
					25'h19: cart_game_o     <= dl_data_i;
					default: ;
				endcase

				// ========================================
				// CHIP chunks
				// ========================================
				if (align_o) begin
					hdr_cnt <= 4'd1;
				end else if (payload_o) begin
					blk_len <= blk_len - 32'd1;
				end else if (in_chunks) begin
					// Counter wraps to zero after offset 15
					hdr_cnt <= hdr_cnt + 4'd1;
					case (hdr_cnt)
						4'd4:  blk_len[31:24]     <= dl_data_i;
						4'd5:  blk_len[23:16]     <= dl_data_i;
						4'd6:  blk_len[15:8]      <= dl_data_i;
						4'd7:  blk_len[7:0]       <= dl_data_i;
						4'd8:  blk_len            <= blk_len - CHIP_HDR_LEN;
						4'd9:  bank_type_o        <= dl_data_i;
						4'd10: bank_num_o[15:8]   <= dl_data_i;
						4'd11: bank_num_o[7:0]    <= dl_data_i;
						4'd12: bank_laddr_o[15:8] <= dl_data_i;
						4'd13: bank_laddr_o[7:0]  <= dl_data_i;
						4'd14: bank_size_o[15:8]  <= dl_data_i;
						4'd15: begin
							bank_size_o[7:0] <= dl_data_i;
							bank_valid_o     <= 1'b1;
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/load_control.sv */
/*
 * Loader control: decodes the download type, keeps the load address,
 * requests one memory write per payload byte and runs the pointer sweep.
 */
`timescale 1ns/1ns
`default_nettype none

module load_control #(
	parameter loader_pkg::mem_addr_t CRT_BASE = 25'h100000
) (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	input  wire                        dl_active_i,
	input  wire loader_pkg::dl_index_t dl_index_i,
	input  wire                        dl_wr_i,
	input  wire loader_pkg::mem_addr_t dl_addr_i,
	input  wire loader_pkg::byte_t     dl_data_i,
	input  wire                        crt_payload_i,
	input  wire                        crt_align_i,
	input  wire                        ptr_hit_i,
	input  wire loader_pkg::byte_t     ptr_data_i,
	input  wire                        writer_busy_i,
	output logic                       crt_byte_o,
	output logic                       prg_payload_o,
	output logic                       prg_addr_lo_o,
	output logic                       prg_addr_hi_o,
	output loader_pkg::mem_addr_t      sweep_addr_o,
	output logic                       req_valid_o,
	output loader_pkg::mem_addr_t      req_addr_o,
	output loader_pkg::byte_t          req_data_o,
	output logic                       inj_done_o,
	output logic                       cart_attached_o
);
	import loader_pkg::*;

	localparam mem_addr_t ALIGN_MASK = (mem_addr_t'(1) << CRT_ALIGN_BITS) - 25'd1;

	logic      is_prg;
	logic      is_crt;
	logic      prg_wr;
	logic      dl_start;
	logic      dl_end;
	logic      active_q;
	logic      prg_q;
	logic      crt_q;
	logic      sweep_q;
	logic      sweep_issue;
	logic      sweep_skip;
	logic      sweep_end;
	mem_addr_t load_addr;

	// ========================================
	// Download decode
	// ========================================
	assign is_prg   = (dl_index_i == IDX_PRG);
	assign is_crt   = (dl_index_i == IDX_CRT) || (dl_index_i == IDX_CRT_ALT);
	assign dl_start = dl_active_i && !active_q;
	assign dl_end   = !dl_active_i && active_q;

	assign prg_wr        = dl_active_i && dl_wr_i && is_prg;
	assign prg_addr_lo_o = prg_wr && (dl_addr_i == 25'd0);
	assign prg_addr_hi_o = prg_wr && (dl_addr_i == 25'd1);
	assign prg_payload_o = prg_wr && (dl_addr_i > 25'd1);
	assign crt_byte_o    = dl_active_i && dl_wr_i && is_crt;

	// Sweep waits on a pointer address until the writer is free
	assign sweep_issue = sweep_q && ptr_hit_i && !writer_busy_i;
	assign sweep_skip  = sweep_q && !ptr_hit_i && (load_addr != MEMINIT_END);
	assign sweep_end   = sweep_q && (load_addr == MEMINIT_END) && !writer_busy_i;

	assign req_valid_o  = prg_payload_o || crt_payload_i || sweep_issue;
	assign req_addr_o   = load_addr;
	assign req_data_o   = sweep_q ? ptr_data_i : dl_data_i;
	assign sweep_addr_o = load_addr;

	// ========================================
	// Sequencing
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active_q        <= 1'b0;
			prg_q           <= 1'b0;
			crt_q           <= 1'b0;
			sweep_q         <= 1'b0;
			inj_done_o      <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			active_q   <= dl_active_i;
			inj_done_o <= sweep_end;
			// Index is only valid while the download runs
			if (dl_active_i) begin
				prg_q <= is_prg;
				crt_q <= is_crt;
			end
			if (dl_start && is_crt) begin
				cart_attached_o <= 1'b0;
			end else if (dl_end && crt_q) begin
				cart_attached_o <= 1'b1;
			end
			if (sweep_end) begin
				sweep_q <= 1'b0;
			end else if (dl_end && prg_q) begin
				sweep_q <= 1'b1;
			end
		end
	end

	// Load address
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			load_addr <= '0;
		end else if (dl_end && prg_q) begin
			load_addr <= '0;
		end else if (prg_addr_lo_o) begin
			load_addr <= mem_addr_t'(dl_data_i);
		end else if (prg_addr_hi_o) begin
			load_addr[15:8] <= dl_data_i;
		end else if (crt_byte_o && (dl_addr_i == 25'd0)) begin
			load_addr <= CRT_BASE;
		end else if (crt_align_i) begin
			// Round up to the next bank boundary
			if ((load_addr & ALIGN_MASK) != '0) begin
				load_addr <= (load_addr | ALIGN_MASK) + 25'd1;
			end
		end else if (req_valid_o || sweep_skip) begin
			load_addr <= load_addr + 25'd1;
		end
	end

	// Writer holds one entry, so every request must find it empty
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		req_valid_o |-> !writer_busy_i);

endmodule

`default_nettype wire

/* hdl/loader_pkg.sv */
/*
 * Shared types, download codes and fixed addresses of the media loader.
 * Loader modules import it; ports refer to its types by scoped name.
 */
`default_nettype none

package loader_pkg;

	// ========================================
	// Data types
	// ========================================
	typedef logic [24:0] mem_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;
	typedef logic [7:0]  dl_index_t;

	// Download type codes sent by the host
	localparam dl_index_t IDX_PRG     = 8'd4;
	localparam dl_index_t IDX_CRT     = 8'd5;
	localparam dl_index_t IDX_CRT_ALT = 8'hC0;

	// ========================================
	// BASIC pointers in zero page
	// ========================================
	localparam mem_addr_t MEMINIT_END    = 25'h100;
	localparam mem_addr_t PTR_TXT_LO     = 25'h2B;
	localparam mem_addr_t PTR_TXT_HI     = 25'h2C;
	// Low byte here, high byte at the next address
	localparam mem_addr_t PTR_VAR        = 25'h2D;
	localparam mem_addr_t PTR_ARY        = 25'h2F;
	localparam mem_addr_t PTR_STR        = 25'h31;
	localparam mem_addr_t PTR_SAVE_START = 25'hAC;
	localparam mem_addr_t PTR_LOAD_END   = 25'hAE;

	// CRT file layout
	localparam mem_addr_t CRT_CHIP_OFFSET = 25'h40;
	localparam int        CHIP_HDR_LEN    = 16;
	// 8 KB bank alignment
	localparam int        CRT_ALIGN_BITS  = 13;

endpackage

`default_nettype wire

/* hdl/mem_slot_writer.sv */
/*
 * Single-entry write buffer toward system memory.
 * Takes one request and issues it in the next slot granted by the memory timing.
 */
`timescale 1ns/1ns
`default_nettype none

module mem_slot_writer (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	input  wire                        req_valid_i,
	input  wire loader_pkg::mem_addr_t req_addr_i,
	input  wire loader_pkg::byte_t     req_data_i,
	input  wire                        slot_i,
	output logic                       busy_o,
	output logic                       mem_we_o,
	output loader_pkg::mem_addr_t      mem_addr_o,
	output loader_pkg::byte_t          mem_data_o
);

	logic slot_q;
	logic slot_rise;

	// Slot window opens on the rising edge
	assign slot_rise = slot_i && !slot_q;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_q   <= 1'b0;
			busy_o   <= 1'b0;
			mem_we_o <= 1'b0;
		end else begin
			slot_q   <= slot_i;
			mem_we_o <= 1'b0;
			if (req_valid_i) begin
				busy_o <= 1'b1;
			end else if (busy_o && slot_rise) begin
				// Write goes out and the buffer frees in the same cycle
				busy_o   <= 1'b0;
				mem_we_o <= 1'b1;
			end
		end
	end

	// Pending address and data
	always_ff @(posedge clk_sys) begin
		if (req_valid_i) begin
			mem_addr_o <= req_addr_i;
			mem_data_o <= req_data_i;
		end
	end

	// A request on a pending entry would overwrite a byte not yet written
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		req_valid_i |-> !busy_o);

endmodule

`default_nettype wire

/* sources.f */
+incdir+testbench
hdl/loader_pkg.sv
hdl/mem_slot_writer.sv
hdl/crt_header_parser.sv
hdl/basic_ptr_patch.sv
hdl/load_control.sv
hdl/c64_loader_top.sv
testbench/tb_c64_loader.sv

/* testbench/tb_loader_model.svh */
/*
 * Reference model and compare tasks for the loader testbench.
 * Included inside the testbench top, so it works on the testbench's own arrays.
 */
`ifndef TB_LOADER_MODEL_SVH
`define TB_LOADER_MODEL_SVH

// PRG payload from the load address, then the BASIC pointers
function automatic void expect_prg(input word_t start, input int count);
	word_t fin;
	mem_addr_t lo_end[4];
	fin = start + word_t'(count);
	lo_end = '{25'h2D, 25'h2F, 25'h31, 25'hAE};
	exp_img.delete();
	for (int i = 0; i < count; i++) begin
		exp_img[mem_addr_t'(start) + mem_addr_t'(i)] = payload[i];
	end
	exp_img[25'h2B] = start[7:0];
	exp_img[25'h2C] = start[15:8];
	exp_img[25'hAC] = start[7:0];
	exp_img[25'hAD] = start[15:8];
	foreach (lo_end[k]) begin
		exp_img[lo_end[k]]         = fin[7:0];
		exp_img[lo_end[k] + 25'd1] = fin[15:8];
	end
endfunction

// Each chunk starts on the next 8 KB boundary at or above the running address
function automatic void expect_crt();
	mem_addr_t addr;
	int        pos;
	addr = CRT_BASE;
	pos  = 0;
	exp_img.delete();
	for (int c = 0; c < 2; c++) begin
		if (addr[12:0] != 13'd0) begin
			addr = {addr[24:13] + 12'd1, 13'd0};
		end
		for (int i = 0; i < chunk_n[c]; i++) begin
			exp_img[addr] = crt_pay[pos];
			addr = addr + 25'd1;
			pos  = pos + 1;
		end
	end
endfunction

task automatic check_byte(input string what, input byte_t got, input byte_t exp);
	if (got !== exp) begin
		$display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_word(input string what, input word_t got, input word_t exp);
	if (got !== exp) begin
		$display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_addr(input string what, input mem_addr_t got, input mem_addr_t exp);
	if (got !== exp) begin
		$display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		abort_run();
	end
endtask

`endif

/* testbench/tb_c64_loader.sv */
/*
 * Testbench for the media loader with a PRG, a CRT and a second PRG under random slot timing.
 * Writes are captured and compared with the reference image.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_c64_loader;
	import loader_pkg::*;

	localparam mem_addr_t CRT_BASE     = 25'h100000;
	localparam int        STREAM_BYTES = 42 + 128 + 27;
	localparam int        WATCHDOG_NS  = 2000 * STREAM_BYTES + 40000;

	logic clk_sys = 1'b0;
	logic reset_n, dl_active_i, dl_wr_i, slot_i;
	dl_index_t dl_index_i;
	mem_addr_t dl_addr_i;
	byte_t     dl_data_i;
	wire dl_wait_o, mem_we_o, inj_done_o, cart_attached_o, bank_valid_o;
	wire mem_addr_t mem_addr_o;
	wire byte_t     mem_data_o, cart_exrom_o, cart_game_o, bank_type_o;
	wire word_t     cart_id_o, bank_num_o, bank_laddr_o, bank_size_o;

	integer seed = 74;
	int     inj_count;
	int     chunk_n[2];
	logic   wait_q = 1'b0;
	byte_t  payload[$];
	byte_t  crt_pay[$];
	byte_t  exp_img[mem_addr_t];
	byte_t  mem_img[mem_addr_t];
	word_t  bank_seen[$];

	c64_loader_top #(.CRT_BASE(CRT_BASE)) dut (.*);

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	`include "tb_loader_model.svh"

	always #4 clk_sys = ~clk_sys;

	// Slot windows at random spacing of 4 to 19 cycles
	initial begin
		int gap;
		slot_i = 1'b0;
		forever begin
			gap = 4 + ({$random(seed)} % 16);
			@(posedge clk_sys) slot_i <= 1'b1;
			@(posedge clk_sys) slot_i <= 1'b0;
			repeat (gap - 2) @(posedge clk_sys);
		end
	end

	// ========================================
	// Capture and compare
	// ========================================
	always @(negedge clk_sys) begin
		if (mem_we_o) begin
			if (mem_img.exists(mem_addr_o)) begin
				$display("Address %h was written more than once", mem_addr_o);
				abort_run();
			end
			mem_img[mem_addr_o] = mem_data_o;
		end
		if (wait_q && !dl_wait_o && !mem_we_o) begin
			$display("dl_wait_o fell at %0t ns without a memory write", $time);
			abort_run();
		end
		wait_q = dl_wait_o;
		if (inj_done_o) inj_count++;
		if (bank_valid_o) begin
			bank_seen.push_back({8'h00, bank_type_o});
			bank_seen.push_back(bank_num_o);
			bank_seen.push_back(bank_laddr_o);
			bank_seen.push_back(bank_size_o);
		end
	end

	task automatic compare_image();
		check_word("write count", word_t'(mem_img.num()), word_t'(exp_img.num()));
		foreach (exp_img[a]) begin
			if (!mem_img.exists(a)) begin
				$display("Address %h was never written", a);
				abort_run();
			end
			check_byte("memory byte", mem_img[a], exp_img[a]);
		end
	endtask

	// One strobe, then hold off while the loader asks to wait
	task automatic send_byte(input mem_addr_t addr, input byte_t data);
		@(posedge clk_sys);
		dl_wr_i   <= 1'b1;
		dl_addr_i <= addr;
		dl_data_i <= data;
		@(posedge clk_sys);
		dl_wr_i <= 1'b0;
		@(negedge clk_sys);
		while (dl_wait_o) @(negedge clk_sys);
	endtask

	task automatic run_prg(input word_t start, input int count);
		payload.delete();
		mem_img.delete();
		inj_count = 0;
		for (int i = 0; i < count; i++) payload.push_back(byte_t'($random(seed)));
		@(posedge clk_sys);
		dl_active_i <= 1'b1;
		dl_index_i  <= IDX_PRG;
		send_byte(25'd0, start[7:0]);
		send_byte(25'd1, start[15:8]);
		for (int i = 0; i < count; i++) send_byte(mem_addr_t'(i + 2), payload[i]);
		@(posedge clk_sys) dl_active_i <= 1'b0;
		while (inj_count == 0) @(negedge clk_sys);
		repeat (40) @(negedge clk_sys);
		check_word("inj_done pulses", word_t'(inj_count), 16'd1);
		expect_prg(start, count);
		compare_image();
	endtask

	task automatic send_chunk(inout mem_addr_t off, input int n, input byte_t ty,
			input word_t bank, input word_t laddr);
		byte_t hdr[16];
		word_t len;
		byte_t b;
		len = word_t'(16 + n);
		hdr = '{8'h43, 8'h48, 8'h49, 8'h50, 8'h00, 8'h00, len[15:8], len[7:0],
			8'h00, ty, bank[15:8], bank[7:0], laddr[15:8], laddr[7:0], 8'h00, byte_t'(n)};
		foreach (hdr[i]) begin
			send_byte(off, hdr[i]);
			off++;
		end
		for (int i = 0; i < n; i++) begin
			b = byte_t'($random(seed));
			crt_pay.push_back(b);
			send_byte(off, b);
			off++;
		end
	endtask

	task automatic run_crt();
		mem_addr_t off;
		mem_addr_t second_base;
		crt_pay.delete();
		mem_img.delete();
		bank_seen.delete();
		chunk_n = '{20, 12};
		@(posedge clk_sys);
		dl_active_i <= 1'b1;
		dl_index_i  <= IDX_CRT;
		for (off = 0; off < 25'h40; off++) begin
			case (off)
				25'h16:  send_byte(off, 8'h00);
				25'h17:  send_byte(off, 8'h13);
				25'h18:  send_byte(off, 8'h01);
				25'h19:  send_byte(off, 8'h00);
				default: send_byte(off, byte_t'(off));
			endcase
		end
		send_chunk(off, chunk_n[0], 8'h00, 16'h0000, 16'h8000);
		send_chunk(off, chunk_n[1], 8'h02, 16'h0001, 16'hA000);
		@(posedge clk_sys) dl_active_i <= 1'b0;
		repeat (4) @(negedge clk_sys);
		check_byte("cart_attached_o", byte_t'(cart_attached_o), 8'd1);
		check_word("cart_id_o", cart_id_o, 16'h0013);
		check_byte("cart_exrom_o", cart_exrom_o, 8'h01);
		check_byte("cart_game_o", cart_game_o, 8'h00);
		check_word("descriptor count", word_t'(bank_seen.size()), 16'd8);
		check_word("bank 0 type", bank_seen[0], 16'h0000);
		check_word("bank 0 number", bank_seen[1], 16'h0000);
		check_word("bank 0 load address", bank_seen[2], 16'h8000);
		check_word("bank 0 size", bank_seen[3], word_t'(chunk_n[0]));
		check_word("bank 1 type", bank_seen[4], 16'h0002);
		check_word("bank 1 number", bank_seen[5], 16'h0001);
		check_word("bank 1 load address", bank_seen[6], 16'hA000);
		check_word("bank 1 size", bank_seen[7], word_t'(chunk_n[1]));
		expect_crt();
		compare_image();
		// First write after the last byte of the first payload opens the second bank
		second_base = CRT_BASE + mem_addr_t'(chunk_n[0] - 1);
		if (!mem_img.next(second_base)) begin
			$display("No write found after the first bank payload");
			abort_run();
		end
		check_addr("second bank base", second_base, CRT_BASE + 25'h2000);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$fatal(1);
	end

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		reset_n     = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i  = '0;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		repeat (10) @(posedge clk_sys);
		reset_n <= 1'b1;
		// Quiet outputs before any strobe
		repeat (20) begin
			@(negedge clk_sys);
			check_byte("idle outputs", byte_t'({mem_we_o, dl_wait_o, bank_valid_o,
				inj_done_o, cart_attached_o}), 8'd0);
			check_word("idle cart_id_o", cart_id_o, 16'd0);
			check_word("idle bank_size_o", bank_size_o, 16'd0);
		end
		run_prg(16'h0801, 40);
		run_crt();
		run_prg(16'hC000, 25);
		check_byte("cart_attached_o after PRG", byte_t'(cart_attached_o), 8'd1);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
